//--- include/gemm_config.svh
// Build-time sizing macros for the GEMM engine: tile count, tile shape, widths, FIFO depths
`ifndef GEMM_CONFIG_SVH
`define GEMM_CONFIG_SVH

// ============================================================
// Array shape
// ============================================================
`define GEMM_NUM_TILES        2    // Compute tiles side by side
`define GEMM_TILE_ROWS        4    // Left rows held per tile
`define GEMM_MAX_VEC_LEN      16   // Longest dot product

// ============================================================
// Datapath widths
// ============================================================
`define GEMM_OPERAND_W        8    // Signed operand bits
`define GEMM_RESULT_W         16   // Accumulator and result bits, wraps

// ============================================================
// Result buffering
// ============================================================
// Kept shallow so that back-pressure reaches the tiles quickly
`define GEMM_TILE_FIFO_DEPTH  2    // Per-tile result FIFO
`define GEMM_HOST_FIFO_DEPTH  4    // Tagged host result FIFO

`endif

//--- src/gemm_data_pkg.sv
// Data types of the GEMM engine: operands, accumulator, tile results and tagged host words
`include "gemm_config.svh"

package gemm_data_pkg;

    // Host word is {tile id, row index, value}, value in the low bits
    localparam int HOST_W = $clog2(`GEMM_NUM_TILES) + $clog2(`GEMM_TILE_ROWS)
                          + `GEMM_RESULT_W;

    // ============================================================
    // Arithmetic types
    // ============================================================
    typedef logic signed [`GEMM_OPERAND_W-1:0] operand_t;   // Signed 8-bit input element

    // Wraps modulo 2^16, no saturation
    typedef logic signed [`GEMM_RESULT_W-1:0]  acc_t;

    // ============================================================
    // Transport types
    // ============================================================
    typedef logic [`GEMM_RESULT_W-1:0] tile_result_t;       // One row sum leaving a tile
    typedef logic [HOST_W-1:0]         host_word_t;         // Tagged word seen by the host

endpackage : gemm_data_pkg

//--- src/gemm_ctrl_pkg.sv
// Control types of the GEMM engine: tile FSM states, tile id, row index, vector length, address
`include "gemm_config.svh"

package gemm_ctrl_pkg;

    typedef logic [$clog2(`GEMM_NUM_TILES)-1:0] tile_id_t;  // Which tile
    typedef logic [$clog2(`GEMM_TILE_ROWS)-1:0] row_idx_t;  // Row inside a tile

    // One extra bit so the full length fits, legal range 1 to max
    typedef logic [$clog2(`GEMM_MAX_VEC_LEN):0] vec_len_t;

    // Left memory address is {row, element}
    // Right memory only uses the element bits
    typedef logic [$clog2(`GEMM_TILE_ROWS*`GEMM_MAX_VEC_LEN)-1:0] mem_addr_t;

    // Tile sequencer
    typedef enum logic [1:0] {
        ST_IDLE,    // Waiting for start
        ST_RUN,     // Issuing operand reads
        ST_FLUSH,   // Last product still in the memory pipe
        ST_PUSH     // Row sum waiting for FIFO space
    } tile_state_t;

endpackage : gemm_ctrl_pkg

//--- src/result_fifo.sv
// Synchronous circular FIFO with a type-parameter payload, serving tile and host result buffers
`include "gemm_config.svh"

module result_fifo #(
    parameter int  DEPTH     = `GEMM_HOST_FIFO_DEPTH,
    parameter type payload_t = logic [`GEMM_RESULT_W-1:0]
) (
    input  logic     i_clk,
    input  logic     i_reset_n,
    input  logic     i_wr_en,
    input  payload_t i_wr_data,
    input  logic     i_rd_en,
    output payload_t o_rd_data,             // Head word, combinational
    output logic     o_full,
    output logic     o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;              // Occupancy

    // ============================================================
    // Storage
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    assign o_rd_data = mem[rd_ptr];

    // ============================================================
    // Pointers and occupancy
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_wr_en, i_rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    assign o_full  = (count == CNT_W'(DEPTH));
    assign o_empty = (count == '0);

    // Producers and consumers watch the flags
    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_wr_en |-> !o_full);
    a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_rd_en |-> !o_empty);

endmodule : result_fifo

//--- src/gemm_tile.sv
// Compute tile: left and right operand memories, row and element sequencer, multiply-accumulate
`include "gemm_config.svh"

module gemm_tile
    import gemm_data_pkg::*, gemm_ctrl_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_reset_n,
    // Host load port
    input  logic         i_wr_en,
    input  logic         i_wr_right,        // Low selects the left memory
    input  mem_addr_t    i_wr_addr,
    input  operand_t     i_wr_data,
    // Run control
    input  logic         i_start,
    input  vec_len_t     i_vec_len,
    // Result FIFO side
    input  logic         i_fifo_full,
    output logic         o_result_valid,
    output tile_result_t o_result_data,
    output logic         o_finished,        // Last row pushed
    output logic         o_active
);

    localparam int ELEM_W = $clog2(`GEMM_MAX_VEC_LEN);

    // ============================================================
    // Operand memories
    // ============================================================
    operand_t mem_left  [`GEMM_TILE_ROWS*`GEMM_MAX_VEC_LEN];
    operand_t mem_right [`GEMM_MAX_VEC_LEN];
    operand_t left_q;                       // Registered read data
    operand_t right_q;

    tile_state_t        state;
    row_idx_t           row;
    logic [ELEM_W-1:0]  elem;
    logic [ELEM_W-1:0]  last_elem;
    vec_len_t           vec_len_q;
    logic               rd_vld;             // left_q and right_q hold a live pair
    mem_addr_t          rd_addr;
    acc_t               acc;
    acc_t               prod;
    logic               push_ok;

    assign rd_addr = {row, elem};

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            if (i_wr_right) begin
                mem_right[i_wr_addr[ELEM_W-1:0]] <= i_wr_data;
            end else begin
                mem_left[i_wr_addr] <= i_wr_data;
            end
        end
        left_q  <= mem_left[rd_addr];       // One cycle read latency
        right_q <= mem_right[elem];
    end

    // ============================================================
    // Row and element sequencer
    // ============================================================
    assign last_elem = ELEM_W'(vec_len_q - 1'b1);
    assign push_ok   = (state == ST_PUSH) && !i_fifo_full;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state  <= ST_IDLE;
            row    <= '0;
            elem   <= '0;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= (state == ST_RUN);    // Data lands one cycle after the address
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state <= ST_RUN;
                        row   <= '0;
                        elem  <= '0;
                    end
                end
                ST_RUN: begin
                    if (elem == last_elem) begin
                        state <= ST_FLUSH;
                    end else begin
                        elem <= elem + 1'b1;
                    end
                end
                ST_FLUSH: state <= ST_PUSH; // Absorb the final product
                ST_PUSH: begin
                    if (push_ok) begin      // Hold here while the FIFO is full
                        elem  <= '0;
                        row   <= row + 1'b1;
                        state <= (row == row_idx_t'(`GEMM_TILE_ROWS-1)) ? ST_IDLE : ST_RUN;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ============================================================
    // Multiply-accumulate
    // ============================================================
    assign prod = acc_t'(left_q) * acc_t'(right_q);   // Sign-extended, product fits 16 bits

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_start) begin
            vec_len_q <= i_vec_len;
            acc       <= '0;
        end else if (push_ok) begin
            acc <= '0;                      // Fresh sum for the next row
        end else if (rd_vld) begin
            acc <= acc + prod;              // Modulo 2^16
        end
    end

    assign o_result_valid = push_ok;
    assign o_result_data  = tile_result_t'(acc);
    assign o_finished     = push_ok && (row == row_idx_t'(`GEMM_TILE_ROWS-1));
    assign o_active       = (state != ST_IDLE);

    // Top level must only start an idle tile with a legal length
    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_start |-> (state == ST_IDLE));
    a_vec_len_legal: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_start |-> (i_vec_len != '0 && i_vec_len <= vec_len_t'(`GEMM_MAX_VEC_LEN)));

endmodule : gemm_tile

//--- src/result_arbiter.sv
// Round-robin result collector from the tile FIFOs into the host FIFO, with per-tile row tags
`include "gemm_config.svh"

module result_arbiter
    import gemm_data_pkg::*, gemm_ctrl_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic [`GEMM_NUM_TILES-1:0]  i_tile_start,   // Clears that tile's row tag
    // Tile FIFO heads
    input  tile_result_t                i_tile_data [`GEMM_NUM_TILES],
    input  logic [`GEMM_NUM_TILES-1:0]  i_tile_empty,
    output logic [`GEMM_NUM_TILES-1:0]  o_tile_rd_en,
    // Host FIFO write side
    input  logic                        i_host_full,
    output logic                        o_host_wr_en,
    output host_word_t                  o_host_data
);

    localparam int N = `GEMM_NUM_TILES;

    tile_id_t  last_grant;                  // Lowest priority next round
    tile_id_t  win;
    logic      found;
    row_idx_t  row_cnt [N];                 // Rows already collected per tile

    // ============================================================
    // Grant selection
    // ============================================================
    always_comb begin
        int idx;
        win   = last_grant;
        found = 1'b0;
        for (int off = 1; off <= N; off++) begin
            idx = (int'(last_grant) + off) % N; // Scan starts after the last winner
            if (!found && !i_tile_empty[idx]) begin
                found = 1'b1;
                win   = tile_id_t'(idx);
            end
        end
    end

    assign o_host_wr_en = found && !i_host_full;    // One word per cycle
    assign o_tile_rd_en = o_host_wr_en ? (N'(1) << win) : '0;
    assign o_host_data  = {win, row_cnt[win], i_tile_data[win]};

    // ============================================================
    // Fairness pointer and row tags
    // ============================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            last_grant <= tile_id_t'(N-1);  // Tile 0 first after reset
        end else if (o_host_wr_en) begin
            last_grant <= win;
        end
    end

    for (genvar t = 0; t < N; t++) begin : gen_row_cnt
        always_ff @(posedge i_clk) begin
            if (!i_reset_n) begin
                row_cnt[t] <= '0;
            end else if (i_tile_start[t]) begin
                row_cnt[t] <= '0;           // New run restarts at row 0
            end else if (o_tile_rd_en[t]) begin
                row_cnt[t] <= row_cnt[t] + 1'b1;
            end
        end
    end

    // A tile is restarted only after its FIFO has drained
    a_no_pop_at_start: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_tile_start & o_tile_rd_en) == '0);

endmodule : result_arbiter

//--- src/engine_top.sv
// GEMM engine top: load fan-out, tile enables, tiles with result FIFOs, arbiter, host FIFO, status
`include "gemm_config.svh"

module engine_top
    import gemm_data_pkg::*, gemm_ctrl_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Operand load, one strobe may hit several tiles
    input  logic                        i_load_valid,
    input  logic [`GEMM_NUM_TILES-1:0]  i_load_tile_mask,
    input  logic                        i_load_right,
    input  mem_addr_t                   i_load_addr,
    input  operand_t                    i_load_data,
    // Run control
    input  logic                        i_start,
    input  logic [`GEMM_NUM_TILES-1:0]  i_tile_en,
    input  vec_len_t                    i_vec_len,
    // Host result port
    input  logic                        i_result_ren,
    output host_word_t                  o_result_rdata,
    output logic                        o_result_empty,
    output logic                        o_busy,
    output logic                        o_done
);

    localparam int N = `GEMM_NUM_TILES;

    logic [N-1:0]  tile_wr_en, tile_start, tile_active, tile_finished, pending;
    logic [N-1:0]  tile_valid, fifo_full, fifo_empty, fifo_rd_en;
    tile_result_t  tile_data [N];
    tile_result_t  fifo_data [N];
    logic          start_ok, all_clear, host_wr_en, host_full;
    host_word_t    host_wdata;

    assign start_ok   = i_start && !o_busy;             // Starts while busy are dropped
    assign tile_wr_en = {N{i_load_valid}} & i_load_tile_mask;
    assign tile_start = {N{start_ok}} & i_tile_en;

    // ============================================================
    // Tiles and their result FIFOs
    // ============================================================
    for (genvar t = 0; t < N; t++) begin : gen_tile
        gemm_tile u_tile (
            .i_clk(i_clk), .i_reset_n(i_reset_n),
            .i_wr_en(tile_wr_en[t]), .i_wr_right(i_load_right),
            .i_wr_addr(i_load_addr), .i_wr_data(i_load_data),
            .i_start(tile_start[t]), .i_vec_len(i_vec_len),
            .i_fifo_full(fifo_full[t]), .o_result_valid(tile_valid[t]),
            .o_result_data(tile_data[t]), .o_finished(tile_finished[t]),
            .o_active(tile_active[t])
        );
        result_fifo #(.DEPTH(`GEMM_TILE_FIFO_DEPTH), .payload_t(tile_result_t)) u_tile_fifo (
            .i_clk(i_clk), .i_reset_n(i_reset_n),
            .i_wr_en(tile_valid[t]), .i_wr_data(tile_data[t]),
            .i_rd_en(fifo_rd_en[t]), .o_rd_data(fifo_data[t]),
            .o_full(fifo_full[t]), .o_empty(fifo_empty[t])
        );
    end

    result_arbiter u_arbiter (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_tile_start(tile_start),
        .i_tile_data(fifo_data), .i_tile_empty(fifo_empty), .o_tile_rd_en(fifo_rd_en),
        .i_host_full(host_full), .o_host_wr_en(host_wr_en), .o_host_data(host_wdata)
    );

    result_fifo #(.DEPTH(`GEMM_HOST_FIFO_DEPTH), .payload_t(host_word_t)) u_host_fifo (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_wr_en(host_wr_en), .i_wr_data(host_wdata),
        .i_rd_en(i_result_ren), .o_rd_data(o_result_rdata),
        .o_full(host_full), .o_empty(o_result_empty)
    );

    // ============================================================
    // Busy and done status
    // ============================================================
    assign all_clear = (pending == '0) && (&fifo_empty);   // Nothing left to drain

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            pending <= '0;
            o_busy  <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            pending <= (pending | tile_start) & ~tile_finished;
            o_done  <= 1'b0;
            if (start_ok) begin
                o_busy <= 1'b1;
            end else if (o_busy && all_clear) begin
                o_busy <= 1'b0;             // Falls as done pulses
                o_done <= 1'b1;
            end
        end
    end

    // Run tracking here must agree with each tile's own FSM
    a_pending_matches: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        pending == tile_active);

endmodule : engine_top

//--- dv/tb_engine_top.sv
// Table-driven testbench for engine_top: operand model, load and start driver, tagged result checks
`include "gemm_config.svh"

module tb_engine_top
    import gemm_data_pkg::*, gemm_ctrl_pkg::*;
();

    localparam int N          = `GEMM_NUM_TILES;
    localparam int ROWS       = `GEMM_TILE_ROWS;
    localparam int VMAX       = `GEMM_MAX_VEC_LEN;
    localparam int VAL_W      = `GEMM_RESULT_W;
    localparam int NUM_TESTS  = 5;
    localparam int WAIT_LIMIT = 2000;       // Cycles before a wait gives up
    localparam int HOLD_CYC   = 200;        // Host read stall under back-pressure

    logic         i_clk;
    logic         i_reset_n;
    logic         i_load_valid;
    logic [N-1:0] i_load_tile_mask;
    logic         i_load_right;
    mem_addr_t    i_load_addr;
    operand_t     i_load_data;
    logic         i_start;
    logic [N-1:0] i_tile_en;
    vec_len_t     i_vec_len;
    logic         i_result_ren;
    host_word_t   o_result_rdata;
    logic         o_result_empty;
    logic         o_busy;
    logic         o_done;

    integer     seed;
    int         checks;
    int         errors;
    logic       timed_out;
    operand_t   left_m  [N][ROWS*VMAX];     // Model of each tile's memories
    operand_t   right_m [N][VMAX];
    host_word_t exp_q   [N][$];             // Expected words per tile, row order

    // ============================================================
    // Test table columns
    // ============================================================
    string        t_name      [NUM_TESTS];
    logic [N-1:0] t_load_mask [NUM_TESTS];  // Zero keeps memories as loaded before
    logic [N-1:0] t_tile_en   [NUM_TESTS];
    vec_len_t     t_vec_len   [NUM_TESTS];
    logic         t_random    [NUM_TESTS];  // Low gives extreme operands that wrap
    logic         t_hold      [NUM_TESTS];  // Host holds off reads first

    engine_top i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic add_test(input int k, input string name, input logic [N-1:0] mask,
                            input logic [N-1:0] en, input vec_len_t len, input logic rnd,
                            input logic hold);
        t_name[k]      = name;
        t_load_mask[k] = mask;
        t_tile_en[k]   = en;
        t_vec_len[k]   = len;
        t_random[k]    = rnd;
        t_hold[k]      = hold;
    endtask

    task automatic check_word(input string name, input host_word_t exp, input host_word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ============================================================
    // Operand loading and reference model
    // ============================================================
    function automatic operand_t extreme_value(input int t, input int r, input int e,
                                               input logic right);
        if (right) begin
            return (e == VMAX-1) ? operand_t'(-128) : operand_t'(127 - e);
        end
        // Near full-scale rows, distinct per address
        return ((r + t) % 2 == 1) ? operand_t'(-128 + r*VMAX + e)
                                  : operand_t'(127 - r*VMAX - e);
    endfunction

    task automatic load_word(input logic [N-1:0] mask, input logic right, input int addr,
                             input operand_t data);
        @(negedge i_clk);
        i_load_valid     = 1'b1;
        i_load_tile_mask = mask;
        i_load_right     = right;
        i_load_addr      = mem_addr_t'(addr);
        i_load_data      = data;
    endtask

    task automatic load_operands(input int k);
        operand_t v;
        if (t_load_mask[k] == '0) return;
        for (int e = 0; e < VMAX; e++) begin    // One strobe reaches every masked tile
            v = t_random[k] ? operand_t'($random(seed)) : extreme_value(0, 0, e, 1'b1);
            load_word(t_load_mask[k], 1'b1, e, v);
            for (int t = 0; t < N; t++) begin
                if (t_load_mask[k][t]) right_m[t][e] = v;
            end
        end
        for (int t = 0; t < N; t++) begin       // Left rows differ per tile
            if (t_load_mask[k][t]) begin
                for (int a = 0; a < ROWS*VMAX; a++) begin
                    v = t_random[k] ? operand_t'($random(seed))
                                    : extreme_value(t, a / VMAX, a % VMAX, 1'b0);
                    load_word(N'(1) << t, 1'b0, a, v);
                    left_m[t][a] = v;
                end
            end
        end
        @(negedge i_clk);
        i_load_valid = 1'b0;
    endtask

    task automatic build_expected(input int k);
        int s;
        for (int t = 0; t < N; t++) begin
            exp_q[t].delete();
            if (t_tile_en[k][t]) begin
                for (int r = 0; r < ROWS; r++) begin
                    s = 0;
                    for (int e = 0; e < int'(t_vec_len[k]); e++) begin
                        s += int'(left_m[t][r*VMAX + e]) * int'(right_m[t][e]);
                    end
                    exp_q[t].push_back({tile_id_t'(t), row_idx_t'(r), tile_result_t'(s)});
                end
            end
        end
    endtask

    task automatic take_word(input string name, input host_word_t w);
        int         tid;
        host_word_t exp;
        tid = int'(w[VAL_W + $bits(row_idx_t) +: $bits(tile_id_t)]);   // Tag above row and value
        if (exp_q[tid].size() == 0) begin
            errors++;
            $display("%s: unexpected word %h from tile %0d", name, w, tid);
        end else begin
            exp = exp_q[tid].pop_front();
            check_word($sformatf("%s tile%0d", name, tid), exp, w);
        end
    endtask

    // ============================================================
    // One table row: load, start, optional stall, drain
    // ============================================================
    task automatic run_test(input int k);
        int   errs_before;
        int   words;
        int   cyc;
        logic done_seen;
        errs_before = errors;
        words       = 0;
        done_seen   = 1'b0;
        load_operands(k);
        build_expected(k);
        check_flag({t_name[k], " idle before start"}, 1'b0, o_busy);
        @(negedge i_clk);
        i_start   = 1'b1;
        i_tile_en = t_tile_en[k];
        i_vec_len = t_vec_len[k];
        @(negedge i_clk);
        i_start = 1'b0;
        cyc = 0;
        while (o_busy !== 1'b1 && cyc < WAIT_LIMIT) begin
            @(negedge i_clk);
            cyc++;
        end
        if (o_busy !== 1'b1) begin
            timed_out = 1'b1;
            errors++;
            $display("%s: o_busy never rose after start", t_name[k]);
            return;
        end
        if (t_hold[k]) begin
            for (int c = 0; c < HOLD_CYC; c++) begin   // Results pile up with nowhere to go
                check_flag({t_name[k], " busy held"}, 1'b1, o_busy);
                check_flag({t_name[k], " no early done"}, 1'b0, o_done);
                @(negedge i_clk);
            end
        end
        cyc = 0;
        while (!(done_seen && o_result_empty) && cyc < WAIT_LIMIT) begin
            if (o_done === 1'b1) begin
                if (done_seen) begin
                    errors++;
                    $display("%s: o_done pulsed more than once", t_name[k]);
                end
                done_seen = 1'b1;
                check_flag({t_name[k], " busy at done"}, 1'b0, o_busy);
            end
            i_result_ren = !o_result_empty;     // Pop the head shown this cycle
            if (!o_result_empty) begin
                take_word(t_name[k], o_result_rdata);
                words++;
            end
            @(negedge i_clk);
            cyc++;
        end
        i_result_ren = 1'b0;
        if (!(done_seen && o_result_empty)) begin
            timed_out = 1'b1;
            errors++;
            $display("%s: results did not drain within %0d cycles", t_name[k], WAIT_LIMIT);
            return;
        end
        for (int t = 0; t < N; t++) begin
            if (exp_q[t].size() != 0) begin
                errors++;
                $display("%s: %0d words from tile %0d never arrived",
                         t_name[k], exp_q[t].size(), t);
            end
        end
        $display("%-18s %0d words read, %0d errors", t_name[k], words, errors - errs_before);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        seed             = 32'h78bb;
        checks           = 0;
        errors           = 0;
        timed_out        = 1'b0;
        i_reset_n        = 1'b0;
        i_load_valid     = 1'b0;
        i_load_tile_mask = '0;
        i_load_right     = 1'b0;
        i_load_addr      = '0;
        i_load_data      = '0;
        i_start          = 1'b0;
        i_tile_en        = '0;
        i_vec_len        = vec_len_t'(1);
        i_result_ren     = 1'b0;
        //       idx name                load   en     len     rand  hold
        add_test(0, "single_tile",      2'b01, 2'b01, 5'd5,  1'b1, 1'b0);
        add_test(1, "broadcast_len1",   2'b11, 2'b11, 5'd1,  1'b1, 1'b0);
        add_test(2, "broadcast_wrap16", 2'b11, 2'b11, 5'd16, 1'b0, 1'b0);
        add_test(3, "back_pressure",    2'b11, 2'b11, 5'd16, 1'b1, 1'b1);
        add_test(4, "retain_tile1",     2'b00, 2'b10, 5'd16, 1'b1, 1'b0);
        repeat (10) @(negedge i_clk);
        i_reset_n = 1'b1;
        @(negedge i_clk);
        check_flag("reset result_empty", 1'b1, o_result_empty);
        check_flag("reset busy", 1'b0, o_busy);
        check_flag("reset done", 1'b0, o_done);
        $display("%-18s %0d errors", "reset_state", errors);
        for (int k = 0; k < NUM_TESTS; k++) begin
            if (timed_out) break;
            run_test(k);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors%s", NUM_TESTS, checks, errors,
                 timed_out ? ", stopped on timeout" : "");
        if (errors == 0 && !timed_out) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_engine_top

//--- sim.f
+incdir+include
src/gemm_data_pkg.sv
src/gemm_ctrl_pkg.sv
src/result_fifo.sv
src/gemm_tile.sv
src/result_arbiter.sv
src/engine_top.sv
dv/tb_engine_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the engine_top testbench with Verilator, runs it and checks the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_engine_top --Mdir "$BUILD_DIR" -o tb_engine_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_engine_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
